// ==== sprite_cfg.svh ====
// raster, scaling and memory map constants; included by the RTL, the package and the testbench
`ifndef SPRITE_CFG_SVH
`define SPRITE_CFG_SVH

// object table geometry
`define MAX_SPRITES    2
// object bytes are x, y, bitmap offset, size {w-1, h-1}
`define OBJ_BYTES      4
`define OBJ_REGION_SZ  (`OBJ_BYTES * `MAX_SPRITES)

// host memory map, bitmap fills the gap up to the control byte
`define BITMAP_BASE    8
`define BITMAP_BYTES   55
// bit 0 bitmap write enable, bit 1 staging ready
`define CONTROL_ADDR   63

// physical to logical pixel scaling, 4x
`define SCALE_SHIFT    2

// reduced raster for short simulations
`define H_ACTIVE       64
`define H_FRONT        4
`define H_SYNC         8
`define H_BACK         4
`define V_ACTIVE       32
`define V_FRONT        1
`define V_SYNC         2
`define V_BACK         1
`define SYNC_POL       1

`endif

// ==== sprite_pkg.sv ====
// shared types of the sprite engine, referenced by scoped names from RTL and testbench
`include "sprite_cfg.svh"

package sprite_pkg;

    // host bus address and data byte
    typedef logic [5:0] addr_t;
    typedef logic [7:0] byte_t;

    // physical pixel position from the raster counter
    typedef logic [9:0] coord_t;
    // position after downscaling
    typedef logic [7:0] lcoord_t;
    // byte index into the bitmap store
    typedef logic [5:0] bmp_addr_t;

    // one host bus request as seen at the pins
    typedef struct packed {
        logic [1:0]  write_n;
        logic [1:0]  read_n;
        addr_t       address;
        logic [31:0] wdata;
    } bus_req_t;

    // raster state for the current pixel
    typedef struct packed {
        coord_t pix_x;
        coord_t pix_y;
        logic   visible;
        logic   hsync;
        logic   vsync;
    } raster_t;

    // whole object table, byte 0 in the low bits
    typedef byte_t [`OBJ_REGION_SZ-1:0] obj_table_t;

    // frame commit sequencer
    typedef enum logic [1:0] {
        IDLE,
        COPY,
        DONE
    } commit_state_t;

endpackage

// ==== video_timing.sv ====
// raster counter producing syncs, the visible flag and the pixel position for the sprite engine
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module video_timing (
    input  logic                clk,
    input  logic                rst_n,
    output sprite_pkg::raster_t raster
);

    // line and frame lengths in pixels and lines
    localparam int H_TOTAL = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;

    localparam sprite_pkg::coord_t H_LAST    = sprite_pkg::coord_t'(H_TOTAL - 1);
    localparam sprite_pkg::coord_t V_LAST    = sprite_pkg::coord_t'(V_TOTAL - 1);
    localparam sprite_pkg::coord_t H_VIS_END = sprite_pkg::coord_t'(`H_ACTIVE);
    localparam sprite_pkg::coord_t V_VIS_END = sprite_pkg::coord_t'(`V_ACTIVE);
    localparam sprite_pkg::coord_t HS_START  = sprite_pkg::coord_t'(`H_ACTIVE + `H_FRONT);
    localparam sprite_pkg::coord_t HS_END    = sprite_pkg::coord_t'(`H_ACTIVE + `H_FRONT + `H_SYNC);
    localparam sprite_pkg::coord_t VS_START  = sprite_pkg::coord_t'(`V_ACTIVE + `V_FRONT);
    localparam sprite_pkg::coord_t VS_END    = sprite_pkg::coord_t'(`V_ACTIVE + `V_FRONT + `V_SYNC);
    // level driven while inside the sync pulse
    localparam logic SYNC_ON = 1'(`SYNC_POL);

    sprite_pkg::coord_t h_cnt;
    sprite_pkg::coord_t v_cnt;
    logic               h_in_sync;
    logic               v_in_sync;

    // horizontal counter steps every clock, vertical at the end of each line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (h_cnt == H_LAST) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == V_LAST) ? '0 : v_cnt + 1'b1;
        end else begin
            h_cnt <= h_cnt + 1'b1;
        end
    end

    assign h_in_sync = (h_cnt >= HS_START) && (h_cnt < HS_END);
    assign v_in_sync = (v_cnt >= VS_START) && (v_cnt < VS_END);

    assign raster.pix_x   = h_cnt;
    assign raster.pix_y   = v_cnt;
    assign raster.visible = (h_cnt < H_VIS_END) && (v_cnt < V_VIS_END);
    assign raster.hsync   = h_in_sync ? SYNC_ON : ~SYNC_ON;
    assign raster.vsync   = v_in_sync ? SYNC_ON : ~SYNC_ON;

endmodule

// ==== frame_commit_fsm.sv ====
// frame start sequencer: commits the staging table or raises the host interrupt at each vsync
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module frame_commit_fsm (
    input  logic                clk,
    input  logic                rst_n,
    input  sprite_pkg::raster_t raster,
    input  logic                staging_ready,
    output logic                copy_en,
    output sprite_pkg::addr_t   copy_idx,
    output logic                commit_done,
    output logic                user_interrupt
);

    localparam sprite_pkg::addr_t LAST_IDX = sprite_pkg::addr_t'(`OBJ_REGION_SZ - 1);
    localparam logic SYNC_ON = 1'(`SYNC_POL);

    sprite_pkg::commit_state_t state;
    sprite_pkg::commit_state_t state_nxt;
    logic                      vsync_q;
    logic                      vsync_qq;
    logic                      frame_start;

    // two sync stages, start of frame is seen one cycle after vsync asserts
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vsync_q  <= ~SYNC_ON;
            vsync_qq <= ~SYNC_ON;
        end else begin
            vsync_q  <= raster.vsync;
            vsync_qq <= vsync_q;
        end
    end

    assign frame_start = (vsync_q == SYNC_ON) && (vsync_qq != SYNC_ON);

    always_comb begin
        state_nxt = state;
        case (state)
            sprite_pkg::IDLE: begin
                if (frame_start && staging_ready) begin
                    state_nxt = sprite_pkg::COPY;
                end
            end
            // one byte per cycle until the last object byte
            sprite_pkg::COPY: begin
                if (copy_idx == LAST_IDX) begin
                    state_nxt = sprite_pkg::DONE;
                end
            end
            default: state_nxt = sprite_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state          <= sprite_pkg::IDLE;
            copy_idx       <= '0;
            user_interrupt <= 1'b0;
        end else begin
            state          <= state_nxt;
            copy_idx       <= (state == sprite_pkg::COPY) ? copy_idx + 1'b1 : '0;
            // host missed the frame, ask for a new table
            user_interrupt <= (state == sprite_pkg::IDLE) && frame_start && !staging_ready;
        end
    end

    assign copy_en     = (state == sprite_pkg::COPY);
    // DONE lasts one cycle, this clears the ready bit in the control register
    assign commit_done = (state == sprite_pkg::DONE);

endmodule

// ==== object_table.sv ====
// staging and active sprite object tables with host write, host read and commit copy ports
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module object_table (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   stage_we,
    input  sprite_pkg::addr_t      stage_idx,
    input  sprite_pkg::byte_t      stage_data,
    input  logic                   copy_en,
    input  sprite_pkg::addr_t      copy_idx,
    input  sprite_pkg::addr_t      rd_idx,
    output sprite_pkg::byte_t      rd_data,
    output sprite_pkg::obj_table_t active
);

    // index bits actually needed for the object region
    localparam int IDX_W = $clog2(`OBJ_REGION_SZ);

    sprite_pkg::obj_table_t staging;

    // host fills staging, only the commit copy touches the active table
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            staging <= '0;
            active  <= '0;
        end else begin
            if (stage_we) begin
                staging[stage_idx[IDX_W-1:0]] <= stage_data;
            end
            if (copy_en) begin
                active[copy_idx[IDX_W-1:0]] <= staging[copy_idx[IDX_W-1:0]];
            end
        end
    end

    // host reads see what is on screen
    assign rd_data = active[rd_idx[IDX_W-1:0]];

endmodule

// ==== host_regs.sv ====
// host bus decoder with control register, bitmap store and one-cycle registered read return
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module host_regs (
    input  logic                 clk,
    input  logic                 rst_n,
    input  sprite_pkg::bus_req_t req,
    input  logic                 commit_done,
    input  sprite_pkg::bmp_addr_t bmp_addr [`MAX_SPRITES],
    output sprite_pkg::byte_t    bmp_data [`MAX_SPRITES],
    output logic                 stage_we,
    output sprite_pkg::addr_t    stage_idx,
    output sprite_pkg::byte_t    stage_data,
    output sprite_pkg::addr_t    obj_rd_idx,
    input  sprite_pkg::byte_t    obj_rd_data,
    output logic                 staging_ready,
    output logic [31:0]          data_out,
    output logic                 data_ready
);

    localparam sprite_pkg::addr_t OBJ_END  = sprite_pkg::addr_t'(`OBJ_REGION_SZ);
    localparam sprite_pkg::addr_t BMP_BASE = sprite_pkg::addr_t'(`BITMAP_BASE);
    localparam sprite_pkg::addr_t BMP_END  = sprite_pkg::addr_t'(`BITMAP_BASE + `BITMAP_BYTES);
    localparam sprite_pkg::addr_t CTRL     = sprite_pkg::addr_t'(`CONTROL_ADDR);
    localparam sprite_pkg::bmp_addr_t BMP_SIZE = sprite_pkg::bmp_addr_t'(`BITMAP_BYTES);

    sprite_pkg::byte_t     bitmap_mem [`BITMAP_BYTES];
    sprite_pkg::byte_t     control_reg;
    sprite_pkg::byte_t     rd_byte;
    sprite_pkg::bmp_addr_t bmp_idx;
    logic                  wr_byte;
    logic                  rd_req;
    logic                  in_obj;
    logic                  in_bmp;
    logic                  in_ctrl;

    // only byte writes are honoured, other widths drop silently
    assign wr_byte = (req.write_n == 2'b00);
    assign rd_req  = (req.read_n != 2'b11);

    // region decode
    assign in_obj  = (req.address < OBJ_END);
    assign in_bmp  = (req.address >= BMP_BASE) && (req.address < BMP_END);
    assign in_ctrl = (req.address == CTRL);
    assign bmp_idx = req.address - BMP_BASE;

    // staging writes go straight to the object table
    assign stage_we   = wr_byte && in_obj;
    assign stage_idx  = req.address;
    assign stage_data = req.wdata[7:0];
    assign obj_rd_idx = req.address;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            control_reg <= '0;
            for (int i = 0; i < `BITMAP_BYTES; i++) begin
                bitmap_mem[i] <= '0;
            end
        end else begin
            // bitmap is locked unless the host enabled writes
            if (wr_byte && in_bmp && control_reg[0]) begin
                bitmap_mem[bmp_idx] <= req.wdata[7:0];
            end
            // a host write beats the commit clear in the same cycle
            if (wr_byte && in_ctrl) begin
                control_reg <= req.wdata[7:0];
            end else if (commit_done) begin
                control_reg[1] <= 1'b0;
            end
        end
    end

    assign staging_ready = control_reg[1];

    // renderer fetch ports, out of range gives an empty byte
    for (genvar s = 0; s < `MAX_SPRITES; s++) begin : g_fetch
        assign bmp_data[s] = (bmp_addr[s] < BMP_SIZE) ? bitmap_mem[bmp_addr[s]] : '0;
    end

    always_comb begin
        rd_byte = '0;
        if (in_obj) begin
            rd_byte = obj_rd_data;
        end else if (in_bmp) begin
            rd_byte = bitmap_mem[bmp_idx];
        end else if (in_ctrl) begin
            rd_byte = control_reg;
        end
    end

    // every read is acked next cycle, data only for byte reads
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_ready <= 1'b0;
            data_out   <= '0;
        end else begin
            data_ready <= rd_req;
            data_out   <= (req.read_n == 2'b00) ? {24'b0, rd_byte} : '0;
        end
    end

endmodule

// ==== sprite_renderer.sv ====
// two-stage sprite hit pipeline turning the raster position into a mono pixel with aligned syncs
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_renderer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  sprite_pkg::raster_t    raster,
    input  sprite_pkg::obj_table_t active,
    output sprite_pkg::bmp_addr_t  bmp_addr [`MAX_SPRITES],
    input  sprite_pkg::byte_t      bmp_data [`MAX_SPRITES],
    output logic                   pixel_on,
    output logic                   hsync,
    output logic                   vsync
);

    localparam logic [8:0] BMP_LIMIT = 9'(`BITMAP_BYTES);

    sprite_pkg::lcoord_t    lx;
    sprite_pkg::lcoord_t    ly;
    logic [`MAX_SPRITES-1:0] bit_set;
    logic                   hsync_q;
    logic                   vsync_q;

    // logical coordinate, 4x nearest neighbour
    assign lx = sprite_pkg::lcoord_t'(raster.pix_x >> `SCALE_SHIFT);
    assign ly = sprite_pkg::lcoord_t'(raster.pix_y >> `SCALE_SHIFT);

    for (genvar s = 0; s < `MAX_SPRITES; s++) begin : g_spr
        localparam int BASE = s * `OBJ_BYTES;

        sprite_pkg::byte_t     spr_x;
        sprite_pkg::byte_t     spr_y;
        sprite_pkg::byte_t     spr_off;
        sprite_pkg::byte_t     spr_size;
        logic [4:0]            spr_w;
        logic [4:0]            spr_h;
        logic                  in_box;
        logic [3:0]            dx;
        logic [3:0]            dy;
        logic [8:0]            bit_off;
        logic [8:0]            byte_addr;
        logic                  hit_q;
        sprite_pkg::bmp_addr_t addr_q;
        logic [2:0]            bit_q;

        assign spr_x    = active[BASE + 0];
        assign spr_y    = active[BASE + 1];
        assign spr_off  = active[BASE + 2];
        assign spr_size = active[BASE + 3];
        // size nibbles hold dimension minus one
        assign spr_w    = {1'b0, spr_size[7:4]} + 5'd1;
        assign spr_h    = {1'b0, spr_size[3:0]} + 5'd1;

        // 9-bit compare so sprites near 255 do not wrap
        assign in_box = raster.visible
            && (lx >= spr_x) && ({1'b0, lx} < {1'b0, spr_x} + {4'b0, spr_w})
            && (ly >= spr_y) && ({1'b0, ly} < {1'b0, spr_y} + {4'b0, spr_h});

        assign dx = 4'(lx - spr_x);
        assign dy = 4'(ly - spr_y);

        // row-major, one bit per pixel
        assign bit_off   = {5'b0, dy} * {4'b0, spr_w} + {5'b0, dx};
        assign byte_addr = {1'b0, spr_off} + {3'b0, bit_off[8:3]};

        // stage one, fetch beyond the store counts as a miss
        always_ff @(posedge clk) begin
            if (!rst_n) begin
                hit_q <= 1'b0;
            end else begin
                hit_q <= in_box && (byte_addr < BMP_LIMIT);
            end
        end

        always_ff @(posedge clk) begin
            addr_q <= sprite_pkg::bmp_addr_t'(byte_addr);
            bit_q  <= bit_off[2:0];
        end

        assign bmp_addr[s] = addr_q;
        // lsb first within each byte
        assign bit_set[s]  = hit_q && bmp_data[s][bit_q];
    end

    // stage two, any sprite bit lights the pixel, syncs follow the same two stages
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hsync_q  <= 1'b0;
            vsync_q  <= 1'b0;
            pixel_on <= 1'b0;
            hsync    <= 1'b0;
            vsync    <= 1'b0;
        end else begin
            hsync_q  <= raster.hsync;
            vsync_q  <= raster.vsync;
            pixel_on <= |bit_set;
            hsync    <= hsync_q;
            vsync    <= vsync_q;
        end
    end

endmodule

// ==== sprite_engine_top.sv ====
// sprite display peripheral top: host bus registers, object tables, frame commit and video output
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_engine_top (
    input  logic              clk,
    input  logic              rst_n,
    input  sprite_pkg::addr_t address,
    input  logic [31:0]       data_in,
    input  logic [1:0]        data_write_n,
    input  logic [1:0]        data_read_n,
    output logic [31:0]       data_out,
    output logic              data_ready,
    output logic [7:0]        uo_out,
    output logic              user_interrupt
);

    sprite_pkg::bus_req_t   req;
    sprite_pkg::raster_t    raster;
    sprite_pkg::obj_table_t active;
    sprite_pkg::bmp_addr_t  bmp_addr [`MAX_SPRITES];
    sprite_pkg::byte_t      bmp_data [`MAX_SPRITES];
    sprite_pkg::addr_t      stage_idx;
    sprite_pkg::byte_t      stage_data;
    sprite_pkg::addr_t      obj_rd_idx;
    sprite_pkg::byte_t      obj_rd_data;
    sprite_pkg::addr_t      copy_idx;
    logic                   stage_we;
    logic                   staging_ready;
    logic                   copy_en;
    logic                   commit_done;
    logic                   pixel_on;
    logic                   hsync;
    logic                   vsync;

    // host pins into one request bundle
    assign req = '{write_n: data_write_n, read_n: data_read_n, address: address, wdata: data_in};

    video_timing u_timing (.clk(clk), .rst_n(rst_n), .raster(raster));

    frame_commit_fsm u_commit (
        .clk(clk), .rst_n(rst_n), .raster(raster), .staging_ready(staging_ready),
        .copy_en(copy_en), .copy_idx(copy_idx), .commit_done(commit_done),
        .user_interrupt(user_interrupt)
    );

    object_table u_tables (
        .clk(clk), .rst_n(rst_n), .stage_we(stage_we), .stage_idx(stage_idx),
        .stage_data(stage_data), .copy_en(copy_en), .copy_idx(copy_idx),
        .rd_idx(obj_rd_idx), .rd_data(obj_rd_data), .active(active)
    );

    host_regs u_regs (
        .clk(clk), .rst_n(rst_n), .req(req), .commit_done(commit_done),
        .bmp_addr(bmp_addr), .bmp_data(bmp_data), .stage_we(stage_we),
        .stage_idx(stage_idx), .stage_data(stage_data), .obj_rd_idx(obj_rd_idx),
        .obj_rd_data(obj_rd_data), .staging_ready(staging_ready),
        .data_out(data_out), .data_ready(data_ready)
    );

    sprite_renderer u_render (
        .clk(clk), .rst_n(rst_n), .raster(raster), .active(active),
        .bmp_addr(bmp_addr), .bmp_data(bmp_data), .pixel_on(pixel_on),
        .hsync(hsync), .vsync(vsync)
    );

    // {vsync, hsync, B, G, R}, sprites are white on black
    assign uo_out = {vsync, hsync, {6{pixel_on}}};

endmodule

// ==== sprite_engine_sva.sv ====
// bound assertions on bus acks, interrupt, commit and blanking, attached to the sprite engine top
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_engine_sva (
    input logic              clk,
    input logic              rst_n,
    input sprite_pkg::addr_t address,
    input logic [1:0]        data_write_n,
    input logic [1:0]        data_read_n,
    input logic              data_ready,
    input logic [7:0]        uo_out,
    input logic              user_interrupt,
    input logic              copy_en,
    input logic              commit_done,
    input logic              staging_ready
);

    localparam sprite_pkg::addr_t CTRL = sprite_pkg::addr_t'(`CONTROL_ADDR);

    // number of failed assertions
    int unsigned fail_cnt = 0;
    logic        ctrl_write;

    assign ctrl_write = (data_write_n == 2'b00) && (address == CTRL);

    // every read request gets exactly one ack on the next cycle
    read_ack_a: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read_n != 2'b11) |=> data_ready)
        else begin $error("read request was not acknowledged one cycle later"); fail_cnt++; end

    no_stray_ack_a: assert property (@(posedge clk) disable iff (!rst_n)
        (data_read_n == 2'b11) |=> !data_ready)
        else begin $error("data_ready raised without a read request"); fail_cnt++; end

    irq_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        user_interrupt |=> !user_interrupt)
        else begin $error("user_interrupt held longer than one cycle"); fail_cnt++; end

    // a frame either commits or interrupts but never both
    irq_vs_copy_a: assert property (@(posedge clk) disable iff (!rst_n)
        user_interrupt |-> !copy_en)
        else begin $error("interrupt raised while the commit copy runs"); fail_cnt++; end

    commit_pulse_a: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(copy_en) |-> commit_done)
        else begin $error("commit_done missing after the last copied byte"); fail_cnt++; end

    // a host control write in the same cycle keeps its own value
    ready_clear_a: assert property (@(posedge clk) disable iff (!rst_n)
        (commit_done && !ctrl_write) |=> !staging_ready)
        else begin $error("staging ready bit not cleared by the commit"); fail_cnt++; end

    // sync periods are always outside the visible area
    blank_in_sync_a: assert property (@(posedge clk) disable iff (!rst_n)
        (uo_out[7] || uo_out[6]) |-> (uo_out[5:0] == 6'h00))
        else begin $error("colour output active during a sync pulse"); fail_cnt++; end

endmodule

bind sprite_engine_top sprite_engine_sva sva_i (
    .clk(clk), .rst_n(rst_n), .address(address), .data_write_n(data_write_n),
    .data_read_n(data_read_n), .data_ready(data_ready),
    .uo_out(uo_out), .user_interrupt(user_interrupt), .copy_en(copy_en),
    .commit_done(commit_done), .staging_ready(staging_ready)
);

// ==== tb_clk_gen.sv ====
// testbench clock and reset source, 10 ns clock with reset held low for the first 8 cycles
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // release on a falling edge so the DUT sees a clean first active cycle
    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== sprite_engine_tb.sv ====
// testbench top that runs bus access, frame commit, interrupt and pixel output tests on the engine
`timescale 1ns/1ps
`include "sprite_cfg.svh"

module sprite_engine_tb;

    localparam int H_TOTAL  = `H_ACTIVE + `H_FRONT + `H_SYNC + `H_BACK;
    localparam int V_TOTAL  = `V_ACTIVE + `V_FRONT + `V_SYNC + `V_BACK;
    localparam int FRAME    = H_TOTAL * V_TOTAL;
    localparam int HS_START = `H_ACTIVE + `H_FRONT;
    localparam int VS_START = `V_ACTIVE + `V_FRONT;
    // three edge waits and one full frame scan plus bus traffic
    localparam int MAX_CYCLES = 4 * FRAME + 500;

    logic              clk;
    logic              rst_n;
    sprite_pkg::addr_t address;
    logic [31:0]       data_in;
    logic [1:0]        data_write_n;
    logic [1:0]        data_read_n;
    logic [31:0]       data_out;
    logic              data_ready;
    logic [7:0]        uo_out;
    logic              user_interrupt;

    // shadow state built from the testbench's own writes
    sprite_pkg::byte_t ctrl_shadow;
    sprite_pkg::byte_t staging_shadow [`OBJ_REGION_SZ];
    sprite_pkg::byte_t active_shadow [`OBJ_REGION_SZ];
    sprite_pkg::byte_t bitmap_shadow [`BITMAP_BYTES];

    int errors = 0;
    int checks = 0;
    int tests = 0;
    int mark = 0;
    int cycles = 0;

    tb_clk_gen u_clk (.clk(clk), .rst_n(rst_n));

    sprite_engine_top dut_i (
        .clk(clk), .rst_n(rst_n), .address(address), .data_in(data_in),
        .data_write_n(data_write_n), .data_read_n(data_read_n), .data_out(data_out),
        .data_ready(data_ready), .uo_out(uo_out), .user_interrupt(user_interrupt)
    );

    task automatic expect_equal(string name, logic [31:0] got, logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic expect_true(string what, bit cond);
        checks++;
        assert (cond) else begin
            $display("error at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    // memory map rules applied to the shadow
    function automatic void shadow_write(int addr, sprite_pkg::byte_t data);
        if (addr < `OBJ_REGION_SZ) begin
            staging_shadow[addr] = data;
        end else if (addr >= `BITMAP_BASE && addr < `BITMAP_BASE + `BITMAP_BYTES) begin
            if (ctrl_shadow[0]) begin
                bitmap_shadow[addr - `BITMAP_BASE] = data;
            end
        end else if (addr == `CONTROL_ADDR) begin
            ctrl_shadow = data;
        end
    endfunction

    function automatic sprite_pkg::byte_t shadow_read(int addr);
        if (addr < `OBJ_REGION_SZ) begin
            return active_shadow[addr];
        end else if (addr >= `BITMAP_BASE && addr < `BITMAP_BASE + `BITMAP_BYTES) begin
            return bitmap_shadow[addr - `BITMAP_BASE];
        end else if (addr == `CONTROL_ADDR) begin
            return ctrl_shadow;
        end
        return 8'h00;
    endfunction

    task automatic bus_write(int addr, sprite_pkg::byte_t data);
        shadow_write(addr, data);
        @(negedge clk);
        address      = sprite_pkg::addr_t'(addr);
        data_in      = {24'h0, data};
        data_write_n = 2'b00;
        @(negedge clk);
        data_write_n = 2'b11;
    endtask

    // data and ack are due one cycle after the request
    task automatic read_expect(int addr);
        @(negedge clk);
        address     = sprite_pkg::addr_t'(addr);
        data_read_n = 2'b00;
        @(negedge clk);
        data_read_n = 2'b11;
        expect_equal("data_ready", 32'(data_ready), 32'd1);
        expect_equal($sformatf("data_out of address %0d", addr), data_out,
                     {24'h0, shadow_read(addr)});
    endtask

    // waits for an output vsync edge within two frames
    task automatic wait_vsync_rise();
        logic prev;
        bit   seen;
        int   n;
        prev = 1'b1;
        seen = 1'b0;
        n    = 0;
        while (!seen && n < 2 * FRAME) begin
            @(negedge clk);
            seen = !prev && uo_out[7];
            prev = uo_out[7];
            n++;
        end
        expect_true("no vsync rising edge within two frames", seen);
    endtask

    task automatic count_interrupts(int window, output int hits);
        hits = int'(user_interrupt);
        for (int i = 1; i < window; i++) begin
            @(negedge clk);
            hits += int'(user_interrupt);
        end
    endtask

    // expected pixel from the shadow active table and bitmap with lsb first bits
    function automatic bit expected_pixel(int lx, int ly);
        int sx;
        int sy;
        int off;
        int w;
        int h;
        int bit_pos;
        int addr;
        bit on;
        on = 1'b0;
        for (int s = 0; s < `MAX_SPRITES; s++) begin
            sx  = active_shadow[s * `OBJ_BYTES + 0];
            sy  = active_shadow[s * `OBJ_BYTES + 1];
            off = active_shadow[s * `OBJ_BYTES + 2];
            w   = active_shadow[s * `OBJ_BYTES + 3][7:4] + 1;
            h   = active_shadow[s * `OBJ_BYTES + 3][3:0] + 1;
            if (lx >= sx && lx < sx + w && ly >= sy && ly < sy + h) begin
                bit_pos = (ly - sy) * w + (lx - sx);
                addr    = off + bit_pos / 8;
                if (addr < `BITMAP_BYTES && bitmap_shadow[addr][bit_pos % 8]) begin
                    on = 1'b1;
                end
            end
        end
        return on;
    endfunction

    task automatic end_test(string name);
        tests++;
        $display("test %0d %s: %0d mismatches", tests, name, errors - mark);
        mark = errors;
    endtask

    // run limit
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not complete within %0d cycles", MAX_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        int                hits;
        int                addr;
        int                h;
        int                v;
        int                lit;
        bit                exp_on;
        address      = '0;
        data_in      = '0;
        data_write_n = 2'b11;
        data_read_n  = 2'b11;
        void'($urandom(32'h26bc));
        ctrl_shadow  = 8'h00;
        for (int i = 0; i < `OBJ_REGION_SZ; i++) begin
            staging_shadow[i] = 8'h00;
            active_shadow[i]  = 8'h00;
        end
        for (int i = 0; i < `BITMAP_BYTES; i++) begin
            bitmap_shadow[i] = 8'h00;
        end
        wait (rst_n === 1'b1);
        @(negedge clk);

        // reset values
        expect_equal("user_interrupt", 32'(user_interrupt), 32'd0);
        expect_equal("data_ready", 32'(data_ready), 32'd0);
        expect_equal("uo_out[5:0]", 32'(uo_out[5:0]), 32'd0);
        end_test("reset");

        // control and bitmap read back and the locked bitmap
        bus_write(`CONTROL_ADDR, 8'h01);
        read_expect(`CONTROL_ADDR);
        for (int i = 0; i < 6; i++) begin
            addr = `BITMAP_BASE + int'($urandom_range(`BITMAP_BYTES - 1, 0));
            bus_write(addr, 8'($urandom));
            read_expect(addr);
        end
        bus_write(`CONTROL_ADDR, 8'h00);
        read_expect(`CONTROL_ADDR);
        bus_write(`BITMAP_BASE, ~bitmap_shadow[0]);
        read_expect(`BITMAP_BASE);
        // object reads see the active table
        for (int i = 0; i < `OBJ_REGION_SZ; i++) begin
            bus_write(i, 8'(8'ha0 + i));
            read_expect(i);
        end
        end_test("host registers");

        // ready is clear so the frame start interrupts
        wait_vsync_rise();
        count_interrupts(4, hits);
        expect_equal("user_interrupt high cycles", 32'(hits), 32'd1);
        end_test("frame interrupt");

        // sprite 0 is 8x4 at logical (3,2) on bitmap bytes 0..3
        // sprite 1 sits off screen
        bus_write(`CONTROL_ADDR, 8'h01);
        for (int i = 0; i < 4; i++) begin
            bus_write(`BITMAP_BASE + i, 8'($urandom) | 8'h01);
        end
        bus_write(0, 8'd3);
        bus_write(1, 8'd2);
        bus_write(2, 8'd0);
        bus_write(3, 8'h73);
        bus_write(4, 8'd200);
        bus_write(5, 8'd200);
        bus_write(6, 8'd0);
        bus_write(7, 8'h00);
        bus_write(`CONTROL_ADDR, 8'h02);
        wait_vsync_rise();
        count_interrupts(4, hits);
        expect_equal("user_interrupt high cycles", 32'(hits), 32'd0);
        // copy plus the done cycle
        repeat (`OBJ_REGION_SZ + 4) @(negedge clk);
        for (int i = 0; i < `OBJ_REGION_SZ; i++) begin
            active_shadow[i] = staging_shadow[i];
        end
        ctrl_shadow[1] = 1'b0;
        for (int i = 0; i < `OBJ_REGION_SZ; i++) begin
            read_expect(i);
        end
        read_expect(`CONTROL_ADDR);
        end_test("frame commit");

        // one full frame with the position counted from the output vsync edge
        wait_vsync_rise();
        h   = 0;
        v   = VS_START;
        lit = 0;
        for (int n = 0; n < FRAME; n++) begin
            exp_on = (h < `H_ACTIVE) && (v < `V_ACTIVE)
                && expected_pixel(h >> `SCALE_SHIFT, v >> `SCALE_SHIFT);
            expect_equal($sformatf("uo_out[5:0] at (%0d,%0d)", h, v), 32'(uo_out[5:0]),
                         exp_on ? 32'h3f : 32'h00);
            expect_equal($sformatf("uo_out[6] at (%0d,%0d)", h, v), 32'(uo_out[6]),
                         32'((h >= HS_START) && (h < HS_START + `H_SYNC)));
            expect_equal($sformatf("uo_out[7] at (%0d,%0d)", h, v), 32'(uo_out[7]),
                         32'((v >= VS_START) && (v < VS_START + `V_SYNC)));
            lit += int'(uo_out[5:0] == 6'h3f);
            h++;
            if (h == H_TOTAL) begin
                h = 0;
                v = (v + 1) % V_TOTAL;
            end
            @(negedge clk);
        end
        expect_true("no lit pixel seen on the colour outputs in the scanned frame", lit > 0);
        end_test("pixel output");

        repeat (2) @(negedge clk);
        $display("tests %0d, checks %0d, mismatches %0d, assertion failures %0d",
                 tests, checks, errors, dut_i.sva_i.fail_cnt);
        if (errors == 0 && dut_i.sva_i.fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
sprite_pkg.sv
video_timing.sv
frame_commit_fsm.sv
object_table.sv
host_regs.sv
sprite_renderer.sv
sprite_engine_top.sv
sprite_engine_sva.sv
tb_clk_gen.sv
sprite_engine_tb.sv

// ==== Makefile ====
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP      = sprite_engine_tb
FLIST    = flist.f
OBJ_DIR  = obj_dir
LOG      = sim.log
FAIL_MSG = Errors found
PASS_MSG = No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL"; exit 1; fi
	@if ! grep -q "^$(PASS_MSG)$$" $(LOG); then echo "FAIL: run ended early"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
